/* verilog/kgp_defines.svh */
`ifndef KGP_DEFINES_SVH
`define KGP_DEFINES_SVH

////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////

// Data and instruction word width
`define KGP_XLEN 32

// Architectural register count
`define KGP_NREGS 32

////////////////////////////////////////////////////////////
// Memories and start address
////////////////////////////////////////////////////////////

// Both memories are word addressed
`define KGP_IMEM_DEPTH 256
`define KGP_DMEM_DEPTH 256

// Word address of the first instruction
`define KGP_RESET_PC 0

`endif

/* verilog/kgp_pkg.sv */
`include "kgp_defines.svh"

package kgp_pkg;

	////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		OP_ALU  = 6'h00,
		OP_ADDI = 6'h01,
		OP_LW   = 6'h02,
		OP_SW   = 6'h03,
		OP_BR   = 6'h04,
		OP_BZ   = 6'h05,
		OP_BNZ  = 6'h06,
		OP_BLTZ = 6'h07,
		OP_HALT = 6'h3f
	} opcode_e;

	// Function codes of the register-register format
	typedef enum logic [5:0] {
		FN_ADD = 6'h00,
		FN_SUB = 6'h01,
		FN_AND = 6'h02,
		FN_OR  = 6'h03,
		FN_XOR = 6'h04,
		FN_SLL = 6'h05,
		FN_SRL = 6'h06,
		FN_SRA = 6'h07
	} func_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_ALWAYS, BR_ZERO, BR_NONZERO, BR_NEG
	} br_kind_e;

	////////////////////////////////////////////////////////////
	// Bundles between blocks
	////////////////////////////////////////////////////////////

	typedef struct packed {
		alu_op_e  alu_op;
		logic     use_imm;
		logic     mem_read;
		logic     mem_write;
		logic     reg_write;
		logic     wb_mem;
		br_kind_e br_kind;
		logic     dest_rt;
	} ctrl_t;

	typedef struct packed {
		logic zero;
		logic sign;
		logic carry;
	} flags_t;

	typedef struct packed {
		logic [`KGP_XLEN-1:0]          pc;
		logic [$clog2(`KGP_NREGS)-1:0] rd;
		logic [`KGP_XLEN-1:0]          wdata;
		logic                          wen;
	} retire_t;

endpackage

/* verilog/kgp_control.sv */
module kgp_control import kgp_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start,
	input  opcode_e opcode,
	input  func_e   func,
	output ctrl_t   ctrl,
	output logic    run,
	output logic    halted
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_HALTED
	} state_e;

	state_e state;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	always_comb begin
		// Safe default is a bubble with no side effects
		ctrl.alu_op    = ALU_ADD;
		ctrl.use_imm   = 1'b0;
		ctrl.mem_read  = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.reg_write = 1'b0;
		ctrl.wb_mem    = 1'b0;
		ctrl.br_kind   = BR_NONE;
		ctrl.dest_rt   = 1'b0;
		case (opcode)
			OP_ALU: begin
				ctrl.reg_write = 1'b1;
				case (func)
					FN_ADD:  ctrl.alu_op = ALU_ADD;
					FN_SUB:  ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_XOR:  ctrl.alu_op = ALU_XOR;
					FN_SLL:  ctrl.alu_op = ALU_SLL;
					FN_SRL:  ctrl.alu_op = ALU_SRL;
					FN_SRA:  ctrl.alu_op = ALU_SRA;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_LW: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_mem    = 1'b1;
				ctrl.dest_rt   = 1'b1;
			end
			OP_SW: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			OP_BR:   ctrl.br_kind = BR_ALWAYS;
			OP_BZ:   ctrl.br_kind = BR_ZERO;
			OP_BNZ:  ctrl.br_kind = BR_NONZERO;
			OP_BLTZ: ctrl.br_kind = BR_NEG;
			default: ctrl.br_kind = BR_NONE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (start) state <= ST_RUN;
				ST_RUN:  if (opcode == OP_HALT) state <= ST_HALTED;
				default: state <= ST_HALTED;
			endcase
		end
	end

	assign run    = (state == ST_RUN);
	assign halted = (state == ST_HALTED);

	a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(ctrl.mem_read && ctrl.mem_write));

endmodule

/* verilog/kgp_fetch.sv */
`include "kgp_defines.svh"

module kgp_fetch import kgp_pkg::*; #(
	parameter int IMEM_AW = $clog2(`KGP_IMEM_DEPTH)
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 run,
	input  br_kind_e             br_kind,
	input  flags_t               flags,
	input  logic [`KGP_XLEN-1:0] imm,
	input  logic                 imem_we,
	input  logic [IMEM_AW-1:0]   imem_addr,
	input  logic [`KGP_XLEN-1:0] imem_wdata,
	output logic [`KGP_XLEN-1:0] pc,
	output logic [`KGP_XLEN-1:0] instr
);

	localparam logic [`KGP_XLEN-1:0] RESET_PC = `KGP_RESET_PC;

	logic [`KGP_XLEN-1:0] imem [`KGP_IMEM_DEPTH];

	logic [`KGP_XLEN-1:0] pc_inc;
	logic [`KGP_XLEN-1:0] pc_target;
	logic [`KGP_XLEN-1:0] pc_next;
	logic                 taken;

	////////////////////////////////////////////////////////////
	// Instruction memory
	////////////////////////////////////////////////////////////

	// Program is written through the load port before start
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	// PC wraps onto the array
	assign instr = imem[pc[IMEM_AW-1:0]];

	////////////////////////////////////////////////////////////
	// Next PC
	////////////////////////////////////////////////////////////

	assign pc_inc    = pc + 1;
	assign pc_target = pc_inc + imm;

	// Flags reflect rs + 0 on branch opcodes
	always_comb begin
		case (br_kind)
			BR_ALWAYS:  taken = 1'b1;
			BR_ZERO:    taken = flags.zero;
			BR_NONZERO: taken = !flags.zero;
			BR_NEG:     taken = flags.sign;
			default:    taken = 1'b0;
		endcase
	end

	assign pc_next = taken ? pc_target : pc_inc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else if (run) begin
			pc <= pc_next;
		end
	end

	// Program must not change under a running core
	a_no_load_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		run |-> !imem_we);

endmodule

/* verilog/kgp_alu.sv */
`include "kgp_defines.svh"

module kgp_alu import kgp_pkg::*; (
	input  logic [`KGP_XLEN-1:0]         a,
	input  logic [`KGP_XLEN-1:0]         b,
	input  logic [$clog2(`KGP_XLEN)-1:0] shamt,
	input  alu_op_e                      op,
	output logic [`KGP_XLEN-1:0]         result,
	output flags_t                       flags
);

	logic [`KGP_XLEN:0] sum;
	logic [`KGP_XLEN:0] diff;
	logic               carry;

	// One extra bit keeps the carry out
	assign sum  = {1'b0, a} + {1'b0, b};

	// Top bit set means no borrow
	assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;

	////////////////////////////////////////////////////////////
	// Operation select
	////////////////////////////////////////////////////////////

	always_comb begin
		carry = 1'b0;
		case (op)
			ALU_ADD: begin
				result = sum[`KGP_XLEN-1:0];
				carry  = sum[`KGP_XLEN];
			end
			ALU_SUB: begin
				result = diff[`KGP_XLEN-1:0];
				carry  = diff[`KGP_XLEN];
			end
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			// Shifts take rs and ignore b
			ALU_SLL: result = a << shamt;
			ALU_SRL: result = a >> shamt;
			ALU_SRA: result = $signed(a) >>> shamt;
			default: result = sum[`KGP_XLEN-1:0];
		endcase
	end

	assign flags.zero  = (result == '0);
	assign flags.sign  = result[`KGP_XLEN-1];
	assign flags.carry = carry;

endmodule

/* verilog/kgp_regfile.sv */
`include "kgp_defines.svh"

module kgp_regfile #(
	parameter int AW = $clog2(`KGP_NREGS)
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 we,
	input  logic [AW-1:0]        raddr1,
	input  logic [AW-1:0]        raddr2,
	input  logic [AW-1:0]        waddr,
	input  logic [`KGP_XLEN-1:0] wdata,
	output logic [`KGP_XLEN-1:0] rdata1,
	output logic [`KGP_XLEN-1:0] rdata2
);

	logic [`KGP_XLEN-1:0] regs [`KGP_NREGS];

	// No hardwired zero register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `KGP_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Reads see the old value until the edge
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

/* verilog/kgp_data_mem.sv */
`include "kgp_defines.svh"

module kgp_data_mem #(
	parameter int AW = $clog2(`KGP_DMEM_DEPTH)
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 re,
	input  logic                 we,
	input  logic [`KGP_XLEN-1:0] addr,
	input  logic [`KGP_XLEN-1:0] wdata,
	output logic [`KGP_XLEN-1:0] rdata
);

	logic [`KGP_XLEN-1:0] mem [`KGP_DMEM_DEPTH];
	logic [AW-1:0]        idx;

	// Word index folded onto the array
	assign idx = AW'(addr % `KGP_DMEM_DEPTH);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `KGP_DMEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[idx] <= wdata;
		end
	end

	// Quiet bus unless a load is in flight
	assign rdata = re ? mem[idx] : '0;

endmodule

/* verilog/kgp_core.sv */
`include "kgp_defines.svh"

module kgp_core import kgp_pkg::*; #(
	parameter int IMEM_AW = $clog2(`KGP_IMEM_DEPTH)
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic                 imem_we,
	input  logic [IMEM_AW-1:0]   imem_addr,
	input  logic [`KGP_XLEN-1:0] imem_wdata,
	output logic                 retire_valid,
	output retire_t              retire,
	output logic                 halted
);

	localparam int RAW = $clog2(`KGP_NREGS);

	logic [`KGP_XLEN-1:0] instr;
	logic [`KGP_XLEN-1:0] pc;
	logic [`KGP_XLEN-1:0] imm_ext;
	logic [`KGP_XLEN-1:0] rs_data;
	logic [`KGP_XLEN-1:0] rt_data;
	logic [`KGP_XLEN-1:0] alu_b;
	logic [`KGP_XLEN-1:0] alu_result;
	logic [`KGP_XLEN-1:0] mem_rdata;
	logic [`KGP_XLEN-1:0] wb_data;
	logic [RAW-1:0]       rs;
	logic [RAW-1:0]       rt;
	logic [RAW-1:0]       waddr;
	logic [4:0]           shamt;
	opcode_e              opcode;
	func_e                func;
	ctrl_t                ctrl;
	flags_t               flags;
	logic                 run;
	logic                 imem_load;
	logic                 reg_we;
	logic                 mem_we;

	////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////

	assign opcode  = opcode_e'(instr[31:26]);
	assign rs      = instr[25:21];
	assign rt      = instr[20:16];
	assign shamt   = instr[10:6];
	assign func    = func_e'(instr[5:0]);
	assign imm_ext = {{(`KGP_XLEN-16){instr[15]}}, instr[15:0]};

	// Load port is only open while idle
	assign imem_load = imem_we && !run && !halted;

	// Branches test rs against zero
	assign alu_b = (ctrl.br_kind != BR_NONE) ? '0 :
	               ctrl.use_imm ? imm_ext : rt_data;

	assign waddr   = ctrl.dest_rt ? rt : rs;
	assign wb_data = ctrl.wb_mem ? mem_rdata : alu_result;
	assign reg_we  = run && ctrl.reg_write;
	assign mem_we  = run && ctrl.mem_write;

	kgp_control u_control (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.opcode (opcode),
		.func   (func),
		.ctrl   (ctrl),
		.run    (run),
		.halted (halted)
	);

	kgp_fetch u_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.br_kind    (ctrl.br_kind),
		.flags      (flags),
		.imm        (imm_ext),
		.imem_we    (imem_load),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.pc         (pc),
		.instr      (instr)
	);

	kgp_alu u_alu (
		.a      (rs_data),
		.b      (alu_b),
		.shamt  (shamt),
		.op     (ctrl.alu_op),
		.result (alu_result),
		.flags  (flags)
	);

	kgp_regfile u_regfile (
		.clk    (clk),
		.rst_n  (rst_n),
		.we     (reg_we),
		.raddr1 (rs),
		.raddr2 (rt),
		.waddr  (waddr),
		.wdata  (wb_data),
		.rdata1 (rs_data),
		.rdata2 (rt_data)
	);

	kgp_data_mem u_data_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.re    (ctrl.mem_read),
		.we    (mem_we),
		.addr  (alu_result),
		.wdata (rt_data),
		.rdata (mem_rdata)
	);

	////////////////////////////////////////////////////////////
	// Retirement
	////////////////////////////////////////////////////////////

	// HALT itself retires nothing
	assign retire_valid  = run && (opcode != OP_HALT);
	assign retire.pc     = pc;
	assign retire.rd     = waddr;
	assign retire.wdata  = wb_data;
	assign retire.wen    = reg_we;

endmodule

/* dv/kgp_core_tb.sv */
`include "kgp_defines.svh"

module kgp_core_tb import kgp_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 5;
	localparam int RESET_CYCLES = 2;
	localparam int QUIET_CYCLES = 20;
	localparam int RUN_BUDGET   = 100;
	localparam int PROG_MAX     = 64;
	localparam int NUM_TESTS    = 7;
	localparam int IMEM_AW      = $clog2(`KGP_IMEM_DEPTH);

	// Per test: reset, load, run, quiet window and a few cycles of slack
	localparam int TEST_CYCLES     = RESET_CYCLES + PROG_MAX + RUN_BUDGET + QUIET_CYCLES + 8;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES + 100;

	logic                 clk;
	logic                 rst_n;
	logic                 start;
	logic                 imem_we;
	logic [IMEM_AW-1:0]   imem_addr;
	logic [`KGP_XLEN-1:0] imem_wdata;
	logic                 retire_valid;
	retire_t              retire;
	logic                 halted;

	// Program image and architectural model
	logic [`KGP_XLEN-1:0] prog [`KGP_IMEM_DEPTH];
	logic [`KGP_XLEN-1:0] m_regs [`KGP_NREGS];
	logic [`KGP_XLEN-1:0] m_mem [`KGP_DMEM_DEPTH];
	logic [`KGP_XLEN-1:0] m_pc;
	logic                 model_active;
	logic                 model_halted;

	integer seed;
	string  current_test;
	int     prog_len;
	int     error_count;
	int     check_count;
	int     tests_run;
	int     tests_failed;
	int     test_retired;

	kgp_core u_kgp_core (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.imem_we      (imem_we),
		.imem_addr    (imem_addr),
		.imem_wdata   (imem_wdata),
		.retire_valid (retire_valid),
		.retire       (retire),
		.halted       (halted)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Encoding and model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
	                                      input logic [4:0] sh, input func_e fn);
		return {OP_ALU, rs, rt, 5'd0, sh, fn};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_e op, input logic [4:0] rs,
	                                      input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic bit model_at_halt();
		return prog[m_pc % `KGP_IMEM_DEPTH][31:26] == OP_HALT;
	endfunction

	// Executes one instruction and returns what it should retire
	function automatic retire_t model_step();
		logic [31:0] ins;
		logic [31:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ea;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  sh;
		retire_t     r;
		ins = prog[m_pc % `KGP_IMEM_DEPTH];
		rs = ins[25:21];
		rt = ins[20:16];
		sh = ins[10:6];
		imm = {{16{ins[15]}}, ins[15:0]};
		a = m_regs[rs];
		b = m_regs[rt];
		ea = a + imm;
		r = '0;
		r.pc = m_pc;
		m_pc = m_pc + 1;
		case (opcode_e'(ins[31:26]))
			OP_ALU: begin
				r.wen = 1'b1;
				r.rd = rs;
				case (func_e'(ins[5:0]))
					FN_ADD:  r.wdata = a + b;
					FN_SUB:  r.wdata = a - b;
					FN_AND:  r.wdata = a & b;
					FN_OR:   r.wdata = a | b;
					FN_XOR:  r.wdata = a ^ b;
					FN_SLL:  r.wdata = a << sh;
					FN_SRL:  r.wdata = a >> sh;
					FN_SRA:  r.wdata = $signed(a) >>> sh;
					default: r.wen = 1'b0;
				endcase
			end
			OP_ADDI: begin
				r.wen = 1'b1;
				r.rd = rs;
				r.wdata = ea;
			end
			OP_LW: begin
				r.wen = 1'b1;
				r.rd = rt;
				r.wdata = m_mem[ea % `KGP_DMEM_DEPTH];
			end
			OP_SW:   m_mem[ea % `KGP_DMEM_DEPTH] = b;
			OP_BR:   m_pc = r.pc + 1 + imm;
			OP_BZ:   if (a == 0) m_pc = r.pc + 1 + imm;
			OP_BNZ:  if (a != 0) m_pc = r.pc + 1 + imm;
			OP_BLTZ: if (a[31]) m_pc = r.pc + 1 + imm;
			default: ;
		endcase
		if (r.wen) begin
			m_regs[r.rd] = r.wdata;
		end
		return r;
	endfunction

	// Index and value only mean something on a register write
	function automatic retire_t mask_unwritten(input retire_t r);
		if (!r.wen) begin
			r.rd = '0;
			r.wdata = '0;
		end
		return r;
	endfunction

	task automatic compare_retire(input string test, input retire_t exp, input retire_t act);
		check_count++;
		if (exp !== act) begin
			error_count++;
			$display("MISMATCH test=%s expected pc=%0d rd=%0d wdata=%h wen=%b",
			         test, exp.pc, exp.rd, exp.wdata, exp.wen);
			$display("         actual   pc=%0d rd=%0d wdata=%h wen=%b",
			         act.pc, act.rd, act.wdata, act.wen);
		end
	endtask

	// Compare process, sampled away from the driving edge
	always @(negedge clk) begin
		if (model_active && retire_valid === 1'b1) begin
			test_retired++;
			if (model_halted) begin
				error_count++;
				$display("ERROR test=%s: retire at pc %0d after the core halted",
				         current_test, retire.pc);
			end else if (model_at_halt()) begin
				error_count++;
				$display("ERROR test=%s: core retired pc %0d, which holds HALT",
				         current_test, retire.pc);
				m_pc = m_pc + 1;
			end else begin
				compare_retire(current_test, mask_unwritten(model_step()),
				               mask_unwritten(retire));
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Drivers
	////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	task automatic reset_core();
		next_cycle();
		rst_n = 1'b0;
		start = 1'b0;
		imem_we = 1'b0;
		repeat (RESET_CYCLES) next_cycle();
		rst_n = 1'b1;
		if (retire_valid !== 1'b0 || halted !== 1'b0) begin
			error_count++;
			$display("ERROR test=%s: retire_valid or halted is not low after reset",
			         current_test);
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < prog_len; i++) begin
			imem_we = 1'b1;
			imem_addr = IMEM_AW'(i);
			imem_wdata = prog[i];
			next_cycle();
		end
		imem_we = 1'b0;
	endtask

	task automatic clear_model();
		for (int i = 0; i < `KGP_NREGS; i++) begin
			m_regs[i] = '0;
		end
		for (int i = 0; i < `KGP_DMEM_DEPTH; i++) begin
			m_mem[i] = '0;
		end
		m_pc = `KGP_RESET_PC;
	endtask

	task automatic run_test(input string name);
		int start_errors;
		start_errors = error_count;
		current_test = name;
		test_retired = 0;
		model_active = 1'b0;
		model_halted = 1'b0;
		reset_core();
		load_program();
		clear_model();
		model_active = 1'b1;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		// Hang is caught by the watchdog
		while (halted !== 1'b1) next_cycle();
		if (!model_at_halt()) begin
			error_count++;
			$display("ERROR test=%s: core halted before the program reached HALT at pc %0d",
			         name, m_pc);
		end
		model_halted = 1'b1;
		repeat (QUIET_CYCLES) begin
			next_cycle();
			if (halted !== 1'b1) begin
				error_count++;
				$display("ERROR test=%s: halted dropped without a reset", name);
			end
		end
		model_active = 1'b0;
		tests_run++;
		if (error_count != start_errors) tests_failed++;
		$display("[%s] %0d retired, %0d errors", name, test_retired, error_count - start_errors);
	endtask

	////////////////////////////////////////////////////////////
	// Programs
	////////////////////////////////////////////////////////////

	task automatic build_alu_ops();
		logic [15:0] hi;
		logic [15:0] lo;
		logic [4:0]  sh;
		prog_len = 0;
		// r1..r4 get random 32-bit values
		for (int r = 1; r <= 4; r++) begin
			hi = 16'($random(seed));
			lo = 16'($random(seed));
			emit(enc_i(OP_ADDI, 5'(r), 5'd0, hi));
			emit(enc_r(5'(r), 5'd0, 5'd16, FN_SLL));
			emit(enc_i(OP_ADDI, 5'(r), 5'd0, lo));
		end
		// r10 = rs copy, then r10 op rt
		for (int p = 0; p < 2; p++) begin
			for (int f = 0; f < 8; f++) begin
				sh = 5'($random(seed));
				emit(enc_r(5'd10, 5'd10, 5'd0, FN_XOR));
				emit(enc_r(5'd10, 5'(2 * p + 1), 5'd0, FN_ADD));
				emit(enc_r(5'd10, 5'(2 * p + 2), sh, func_e'(f)));
			end
		end
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
	endtask

	task automatic build_imm_sign();
		prog_len = 0;
		emit(enc_i(OP_ADDI, 5'd5, 5'd0, 16'h7fff));
		emit(enc_i(OP_ADDI, 5'd5, 5'd0, 16'h8000));
		emit(enc_i(OP_ADDI, 5'd6, 5'd0, 16'hffff));
		emit(enc_i(OP_ADDI, 5'd6, 5'd0, 16'h0001));
		// Walk across the signed boundary and back
		emit(enc_i(OP_ADDI, 5'd7, 5'd0, 16'hffff));
		emit(enc_r(5'd7, 5'd0, 5'd1, FN_SRL));
		emit(enc_i(OP_ADDI, 5'd7, 5'd0, 16'h0001));
		emit(enc_i(OP_ADDI, 5'd7, 5'd0, 16'hffff));
		repeat (6) emit(enc_i(OP_ADDI, 5'd8, 5'd0, 16'($random(seed))));
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
	endtask

	task automatic build_load_store();
		logic [7:0]  addr [4];
		logic [7:0]  base;
		logic [15:0] off;
		prog_len = 0;
		base = 8'($random(seed));
		for (int k = 0; k < 4; k++) begin
			addr[k] = base + 8'(k * 61);
			emit(enc_i(OP_ADDI, 5'(k + 1), 5'd0, 16'($random(seed))));
		end
		for (int k = 0; k < 4; k++) begin
			emit(enc_i(OP_SW, 5'd0, 5'(k + 1), {8'h00, addr[k]}));
		end
		for (int k = 0; k < 4; k++) begin
			emit(enc_i(OP_LW, 5'd0, 5'(k + 11), {8'h00, addr[k]}));
		end
		// Register base with a negative offset
		off = {8'h00, addr[0]} - 16'd300;
		emit(enc_i(OP_ADDI, 5'd9, 5'd0, 16'd300));
		emit(enc_i(OP_LW, 5'd9, 5'd15, off));
		// Aliased word, then an untouched one
		emit(enc_i(OP_LW, 5'd0, 5'd16, {8'h00, addr[0]} + 16'd256));
		emit(enc_i(OP_LW, 5'd0, 5'd17, {8'h00, base + 8'd200}));
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
	endtask

	task automatic build_branches();
		prog_len = 0;
		emit(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd5));
		emit(enc_i(OP_ADDI, 5'd2, 5'd0, 16'd1));
		emit(enc_i(OP_ADDI, 5'd1, 5'd0, 16'hffff));
		emit(enc_i(OP_BNZ, 5'd1, 5'd0, 16'hfffd));
		emit(enc_i(OP_BZ, 5'd1, 5'd0, 16'd1));
		emit(enc_i(OP_ADDI, 5'd3, 5'd0, 16'd100));
		emit(enc_i(OP_BZ, 5'd2, 5'd0, 16'd1));
		emit(enc_i(OP_ADDI, 5'd4, 5'd0, 16'hffff));
		emit(enc_i(OP_BLTZ, 5'd4, 5'd0, 16'd1));
		emit(enc_i(OP_ADDI, 5'd3, 5'd0, 16'd200));
		emit(enc_i(OP_BLTZ, 5'd2, 5'd0, 16'd1));
		emit(enc_i(OP_ADDI, 5'd3, 5'd0, 16'd1));
		emit(enc_i(OP_BR, 5'd0, 5'd0, 16'd1));
		emit(enc_i(OP_ADDI, 5'd3, 5'd0, 16'd300));
		emit(enc_i(OP_BNZ, 5'd0, 5'd0, 16'd1));
		emit(enc_i(OP_ADDI, 5'd3, 5'd0, 16'd2));
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
	endtask

	task automatic build_halt();
		prog_len = 0;
		emit(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd1));
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
		emit(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd99));
		emit(enc_i(OP_ADDI, 5'd2, 5'd0, 16'd5));
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
	endtask

	task automatic build_reg_fill();
		prog_len = 0;
		for (int r = 0; r < `KGP_NREGS; r++) begin
			emit(enc_i(OP_ADDI, 5'(r), 5'd0, 16'($random(seed)) | 16'h0001));
		end
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
	endtask

	// Pairwise sums cover every register once
	task automatic build_reset_clear();
		prog_len = 0;
		for (int k = 0; k < `KGP_NREGS / 2; k++) begin
			emit(enc_r(5'(2 * k), 5'(2 * k + 1), 5'd0, FN_ADD));
		end
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
	endtask

	////////////////////////////////////////////////////////////
	// Sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		model_active = 1'b0;
		model_halted = 1'b0;
		seed = 47;
		current_test = "startup";
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		tests_failed = 0;
		build_alu_ops();
		run_test("alu_ops");
		build_imm_sign();
		run_test("imm_sign");
		build_load_store();
		run_test("load_store");
		build_branches();
		run_test("branches");
		build_halt();
		run_test("halt");
		build_reg_fill();
		run_test("reg_fill");
		build_reset_clear();
		run_test("reset_clear");
		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
		         tests_run, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("TIMEOUT: test %s did not finish within the cycle budget", current_test);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+verilog
verilog/kgp_pkg.sv
verilog/kgp_control.sv
verilog/kgp_fetch.sv
verilog/kgp_alu.sv
verilog/kgp_regfile.sv
verilog/kgp_data_mem.sv
verilog/kgp_core.sv
dv/kgp_core_tb.sv

/* Bender.yml */
package:
  name: kgp_core

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/kgp_pkg.sv
      - verilog/kgp_control.sv
      - verilog/kgp_fetch.sv
      - verilog/kgp_alu.sv
      - verilog/kgp_regfile.sv
      - verilog/kgp_data_mem.sv
      - verilog/kgp_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/kgp_core_tb.sv
